//--- source/truncate_pkg.sv
// word geometry constants, delay line sizing and the segmented cluster word type
`default_nettype none

package truncate_pkg;

  // ------------------------------
  // cluster word geometry
  // ------------------------------

  // total number of cluster flag bits latched in one word
  localparam int VPF_WIDTH = 128;

  // each segment truncates on its own, so this sets the carry length
  // of the subtract inside one segment register
  localparam int SEG_WIDTH = 16;

  // number of segments that make up the word
  localparam int NUM_SEGS = VPF_WIDTH / SEG_WIDTH;

  // segments are bundled into groups of this size in the keep chain
  // so that only one keep bit crosses from one group to the next
  localparam int KEEP_GROUP = 4;

  // ------------------------------
  // latch delay line
  // ------------------------------

  // stages in the programmable delay on the latch pulse
  localparam int DELAY_DEPTH = 16;

  // width of the tap select, enough to address every stage
  localparam int DELAY_SEL_WIDTH = 4;

  // ------------------------------
  // cluster word views
  // ------------------------------

  // the same bits are used as one flat vector at the ports and as an array
  // of segments inside the truncator, with segment 0 at the lsb end
  typedef union packed {
    logic [VPF_WIDTH-1:0]               flat;
    logic [NUM_SEGS-1:0][SEG_WIDTH-1:0] seg;
  } vpfs_t;

endpackage

`default_nettype wire

//--- source/latch_delay.sv
// programmable delay line for the latch pulse with a registered load enable
`timescale 1ns/1ns
`default_nettype none

module latch_delay
  import truncate_pkg::*;
(
  input  logic                       clock,
  input  logic                       rst_n,
  input  logic                       latch_in,
  input  logic [DELAY_SEL_WIDTH-1:0] latch_delay,
  output logic                       latch_en
);

  // ------------------------------
  // shift register
  // ------------------------------

  // stage 0 holds latch_in delayed by one clock, and stage n holds it
  // delayed by n + 1 clocks
  logic [DELAY_DEPTH-1:0] delay_line;

  // the selected stage, before the output register
  logic delay_tap;

  // the pulse walks up one stage on every clock
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      delay_line <= '0;
    end else begin
      delay_line <= {delay_line[DELAY_DEPTH-2:0], latch_in};
    end
  end

  // a select of zero still gives one clock of delay
  // which matches the tap numbering of a vendor shift register primitive
  assign delay_tap = delay_line[latch_delay];

  // ------------------------------
  // load enable register
  // ------------------------------

  // latch_en fans out to every segment register in the word
  // so the tap mux is kept out of that path by one more flop
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      latch_en <= 1'b0;
    end else begin
      latch_en <= delay_tap;
    end
  end

  // a latch_in pulse at edge k shows up on latch_en right after
  // edge k + latch_delay + 1, and the segments load at the edge after that

endmodule

`default_nettype wire

//--- source/cluster_segment.sv
// one segment register that either loads new clusters or drops its lowest set bit
`timescale 1ns/1ns
`default_nettype none

module cluster_segment
  import truncate_pkg::*;
(
  input  logic                 clock,
  input  logic                 rst_n,
  input  logic                 latch_en,
  input  logic [SEG_WIDTH-1:0] segment_in,
  input  logic                 keep,
  output logic [SEG_WIDTH-1:0] segment_q
);

  // ------------------------------
  // lowest set bit removal
  // ------------------------------

  // two's complement of the stored value
  // it matches segment_q up to and including the lowest set bit and is
  // inverted above it
  logic [SEG_WIDTH-1:0] segment_neg;

  // segment_q with the lowest set bit cleared, or unchanged when kept
  logic [SEG_WIDTH-1:0] segment_next;

  assign segment_neg = ~segment_q + 1'b1;

  // ~segment_neg has a zero at the lowest set bit and ones everywhere else
  // that segment_q has ones, so the and leaves all other bits in place
  // the position of the bit is never worked out, which keeps this path to
  // one short carry chain plus a gate
  // a high keep forces the mask to all ones so the segment holds
  // an empty segment stays empty since its negation is also zero
  assign segment_next = segment_q & ({SEG_WIDTH{keep}} | ~segment_neg);

  // ------------------------------
  // segment register
  // ------------------------------

  // a load wins over truncation, so a relatch mid drain simply
  // replaces whatever is left of the old word
  always_ff @(posedge clock) begin
    if (!rst_n) begin
      segment_q <= '0;
    end else if (latch_en) begin
      segment_q <= segment_in;
    end else begin
      segment_q <= segment_next;
    end
  end

endmodule

`default_nettype wire

//--- source/segment_keep_chain.sv
// grouped prefix-OR over segment activity that selects which segments hold
`timescale 1ns/1ns
`default_nettype none

module segment_keep_chain
  import truncate_pkg::*;
(
  input  vpfs_t               segments,
  output logic [NUM_SEGS-1:0] segment_keep
);

  // ------------------------------
  // segment activity
  // ------------------------------

  // a segment is active while it still holds at least one cluster
  logic [NUM_SEGS-1:0] segment_active;

  always_comb begin
    for (int seg = 0; seg < NUM_SEGS; seg++) begin
      segment_active[seg] = |segments.seg[seg];
    end
  end

  // ------------------------------
  // grouped keep chain
  // ------------------------------

  // a segment must hold if any lower segment is still active
  // so only the lowest active segment loses a bit on a given clock
  // and the word as a whole drops exactly its lowest set bit
  //
  // the first group ORs its lower members directly
  // every later group starts from the keep bit of the previous group's
  // top segment plus that top segment's own activity, then adds its own
  // lower members, so only one bit ripples between groups
  // segment 0 has nothing below it and is never held
  always_comb begin
    logic group_carry;
    logic top_active;
    logic window;
    int   seg;

    group_carry  = 1'b0;
    top_active   = 1'b0;
    window       = 1'b0;
    seg          = 0;
    segment_keep = '0;

    for (int grp = 0; grp < NUM_SEGS / KEEP_GROUP; grp++) begin
      // the window restarts at every group boundary
      window = top_active;

      for (int mbr = 0; mbr < KEEP_GROUP; mbr++) begin
        seg               = grp * KEEP_GROUP + mbr;
        segment_keep[seg] = window | group_carry;
        window            = window | segment_active[seg];
      end

      // hand the top segment of this group over to the next one
      group_carry = segment_keep[grp * KEEP_GROUP + KEEP_GROUP - 1];
      top_active  = segment_active[grp * KEEP_GROUP + KEEP_GROUP - 1];
    end
  end

  // with all segments empty no keep bit is set, but every segment
  // then maps zero to zero, so the word stays cleared

endmodule

`default_nettype wire

//--- source/truncate_clusters.sv
// cluster truncator top level with the latch delay, keep chain and segment array
`timescale 1ns/1ns
`default_nettype none

module truncate_clusters
  import truncate_pkg::*;
(
  input  logic                       clock,
  input  logic                       rst_n,
  input  logic                       latch_in,
  input  logic [DELAY_SEL_WIDTH-1:0] latch_delay,
  input  logic [VPF_WIDTH-1:0]       vpfs_in,
  output logic [VPF_WIDTH-1:0]       vpfs_out
);

  // segmented view of the incoming cluster flags
  vpfs_t vpfs_in_view;

  // the registered word, one slice per segment instance
  vpfs_t segment_q;

  // load enable from the delay line, high for one cycle per latch
  logic latch_en;

  // hold flags for each segment from the keep chain
  logic [NUM_SEGS-1:0] segment_keep;

  assign vpfs_in_view.flat = vpfs_in;

  // ------------------------------
  // latch timing
  // ------------------------------

  latch_delay latch_delay_inst (
    .clock       (clock),
    .rst_n       (rst_n),
    .latch_in    (latch_in),
    .latch_delay (latch_delay),
    .latch_en    (latch_en)
  );

  // ------------------------------
  // keep chain and segment array
  // ------------------------------

  // the chain looks at the registered word, so the choice of which
  // segment truncates is always made on the current contents
  segment_keep_chain segment_keep_chain_inst (
    .segments     (segment_q),
    .segment_keep (segment_keep)
  );

  for (genvar seg = 0; seg < NUM_SEGS; seg++) begin : gen_segment
    cluster_segment cluster_segment_inst (
      .clock      (clock),
      .rst_n      (rst_n),
      .latch_en   (latch_en),
      .segment_in (vpfs_in_view.seg[seg]),
      .keep       (segment_keep[seg]),
      .segment_q  (segment_q.seg[seg])
    );
  end

  // the downstream encoder sees the word straight from the registers
  assign vpfs_out = segment_q.flat;

endmodule

`default_nettype wire

//--- testbench/tb_truncate_clusters.sv
// self-checking testbench for the cluster truncator, driven from the golden data file
`timescale 1ns/1ns
`default_nettype none

module tb_truncate_clusters
  import truncate_pkg::*;
();

  localparam int MAX_LINES     = 64;
  localparam int RESET_CYCLES  = 8;
  localparam int IDLE_CYCLES   = 20;
  localparam int SETTLE_CYCLES = 20;
  localparam int DRAIN_TIMEOUT = 140;
  localparam int HOLD_CYCLES   = 5;

  logic                       clock;
  logic                       rst_n;
  logic                       latch_in;
  logic [DELAY_SEL_WIDTH-1:0] latch_delay;
  logic [VPF_WIDTH-1:0]       vpfs_in;
  logic [VPF_WIDTH-1:0]       vpfs_out;

  // one entry per data line of the golden file
  int                         gold_num    [MAX_LINES];
  logic [DELAY_SEL_WIDTH-1:0] gold_delay  [MAX_LINES];
  logic [VPF_WIDTH-1:0]       gold_word   [MAX_LINES];
  int                         gold_steps  [MAX_LINES];
  logic [VPF_WIDTH-1:0]       gold_expect [MAX_LINES];
  int                         gold_count;

  int   pass_count;
  int   fail_count;
  // cleared by the first failing check of the running test
  logic test_ok;

  truncate_clusters truncate_clusters_inst (
    .clock       (clock),
    .rst_n       (rst_n),
    .latch_in    (latch_in),
    .latch_delay (latch_delay),
    .vpfs_in     (vpfs_in),
    .vpfs_out    (vpfs_out)
  );

  always #4 clock = ~clock;

  // ------------------------------
  // reference helpers
  // ------------------------------

  // number of set bits, which is also the drain length of a word
  function automatic int count_ones(input logic [VPF_WIDTH-1:0] word);
    int total;
    total = 0;
    for (int b = 0; b < VPF_WIDTH; b++) begin
      if (word[b]) begin
        total++;
      end
    end
    return total;
  endfunction

  // ------------------------------
  // reporting
  // ------------------------------

  // prints the first wrong value of the running test and marks it failed
  task automatic report_mismatch(input string name, input logic [VPF_WIDTH-1:0] expected,
                                 input logic [VPF_WIDTH-1:0] actual);
    if (test_ok) begin
      $display("[FAIL] %s expected %h actual %h", name, expected, actual);
    end
    test_ok = 1'b0;
  endtask

  task automatic report_problem(input string message);
    if (test_ok) begin
      $display("%s", message);
    end
    test_ok = 1'b0;
  endtask

  task automatic close_test(input string name);
    if (test_ok) begin
      pass_count++;
      $display("[PASS] %s", name);
    end else begin
      fail_count++;
    end
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------

  // keeps latch_in low long enough for any old pulse to leave the delay line
  task automatic settle();
    for (int i = 0; i < SETTLE_CYCLES; i++) begin
      @(negedge clock);
      latch_in = 1'b0;
    end
  endtask

  // pulses latch_in for one cycle and returns at the sample point right
  // after the capture edge, which is delay + 2 edges after the pulse edge
  task automatic pulse_latch(input logic [DELAY_SEL_WIDTH-1:0] delay,
                             input logic [VPF_WIDTH-1:0] word);
    @(negedge clock);
    latch_delay = delay;
    vpfs_in     = word;
    latch_in    = 1'b1;
    @(posedge clock);
    @(negedge clock);
    latch_in = 1'b0;
    for (int i = 0; i < int'(delay) + 2; i++) begin
      @(posedge clock);
    end
    @(negedge clock);
  endtask

  // follows the drain one edge at a time from the capture sample point
  task automatic follow_drain(input string name, input logic [VPF_WIDTH-1:0] start_word,
                              input int steps, input logic [VPF_WIDTH-1:0] expected);
    int   step;
    int   first_zero;
    int   ones;
    logic done;
    step       = 0;
    first_zero = -1;
    ones       = count_ones(start_word);
    done       = 1'b0;
    while (!done) begin
      if (vpfs_out === '0 && first_zero < 0) begin
        first_zero = step;
      end
      if (step == steps && vpfs_out !== expected) begin
        report_mismatch($sformatf("%s golden", name), expected, vpfs_out);
      end
      if (step >= steps && first_zero >= 0) begin
        done = 1'b1;
      end else if (step >= DRAIN_TIMEOUT) begin
        report_problem($sformatf("%s did not drain to zero within %0d cycles",
                                 name, DRAIN_TIMEOUT));
        done = 1'b1;
      end else begin
        @(negedge clock);
        step++;
      end
    end
    if (first_zero >= 0) begin
      if (first_zero != ones) begin
        if (test_ok) begin
          $display("[FAIL] %s drain length expected %0d actual %0d", name, ones, first_zero);
        end
        test_ok = 1'b0;
      end
      // an empty word must stay empty
      for (int i = 0; i < HOLD_CYCLES; i++) begin
        @(negedge clock);
        if (vpfs_out !== '0) begin
          report_mismatch($sformatf("%s hold zero", name), '0, vpfs_out);
        end
      end
    end
  endtask

  // ------------------------------
  // main sequence
  // ------------------------------

  initial begin
    int                   fd;
    int                   code;
    int                   num;
    int                   dly;
    int                   steps;
    logic [VPF_WIDTH-1:0] word;
    logic [VPF_WIDTH-1:0] expect_word;
    string                line;
    string                name;

    clock       = 1'b0;
    rst_n       = 1'b0;
    latch_in    = 1'b0;
    latch_delay = '0;
    vpfs_in     = {8{16'h5a3c}};
    pass_count  = 0;
    fail_count  = 0;
    gold_count  = 0;

    fd = $fopen("testbench/truncate_golden.txt", "r");
    if (fd == 0) begin
      $display("the golden data file could not be opened");
      fail_count++;
    end else begin
      while (!$feof(fd) && gold_count < MAX_LINES) begin
        code = $fgets(line, fd);
        if (code > 0 && line.len() > 2 && line.substr(0, 1) != "//") begin
          code = $sscanf(line, "%d %d %h %d %h", num, dly, word, steps, expect_word);
          if (code == 5) begin
            gold_num[gold_count]    = num;
            gold_delay[gold_count]  = DELAY_SEL_WIDTH'(dly);
            gold_word[gold_count]   = word;
            gold_steps[gold_count]  = steps;
            gold_expect[gold_count] = expect_word;
            gold_count++;
          end
        end
      end
      $fclose(fd);
      if (gold_count == 0) begin
        $display("the golden data file holds no test lines");
        fail_count++;
      end
    end

    // reset, then the word must stay empty while no latch arrives
    for (int i = 0; i < RESET_CYCLES; i++) begin
      @(posedge clock);
    end
    @(negedge clock);
    rst_n   = 1'b1;
    test_ok = 1'b1;
    for (int i = 0; i < IDLE_CYCLES; i++) begin
      @(negedge clock);
      if (vpfs_out !== '0) begin
        report_mismatch("reset_idle", '0, vpfs_out);
      end
    end
    close_test("reset_idle");

    // one capture and drain per golden line
    // vpfs_in is inverted after capture so a leak from the input shows up
    for (int i = 0; i < gold_count; i++) begin
      settle();
      test_ok = 1'b1;
      name    = $sformatf("golden_%0d", gold_num[i]);
      pulse_latch(gold_delay[i], gold_word[i]);
      if (vpfs_out !== gold_word[i]) begin
        report_mismatch({name, " capture"}, gold_word[i], vpfs_out);
      end
      vpfs_in = ~gold_word[i];
      follow_drain(name, gold_word[i], gold_steps[i], gold_expect[i]);
      close_test(name);
    end

    // the next line's word lands while the first still has bits left
    for (int i = 0; i + 1 < gold_count; i++) begin
      if (count_ones(gold_word[i]) > int'(gold_delay[i]) + 3) begin
        settle();
        test_ok = 1'b1;
        name    = $sformatf("relatch_%0d_%0d", gold_num[i], gold_num[i+1]);
        pulse_latch(gold_delay[i], gold_word[i]);
        if (vpfs_out !== gold_word[i]) begin
          report_mismatch({name, " first capture"}, gold_word[i], vpfs_out);
        end
        vpfs_in = ~gold_word[i];
        // same delay for both so the first pulse cannot hit a new tap
        pulse_latch(gold_delay[i], gold_word[i+1]);
        if (vpfs_out !== gold_word[i+1]) begin
          report_mismatch({name, " second capture"}, gold_word[i+1], vpfs_out);
        end
        vpfs_in = ~gold_word[i+1];
        follow_drain(name, gold_word[i+1], gold_steps[i+1], gold_expect[i+1]);
        close_test(name);
      end
    end

    $display("tests passed %0d failed %0d", pass_count, fail_count);
    if (fail_count == 0) begin
      $display("ALL TESTS PASSED");
    end else begin
      $display("SOME TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- testbench/truncate_golden.txt
// columns: test number, latch delay, input word (hex), step count n,
// expected word after the n lowest set bits are cleared (hex)

// single bit in segment 0
1 0 00000000000000000000000000000001 1 00000000000000000000000000000000

// top of segment 3 then two bits in segment 4, across a group boundary
2 1 00000000000000038000000000000000 1 00000000000000030000000000000000

// full word, twenty bits cleared across segments 0 and 1
3 7 FFFFFFFFFFFFFFFFFFFFFFFFFFFFFFFF 20 FFFFFFFFFFFFFFFFFFFFFFFFFFF00000

// top bit of the word, checked right at capture
4 15 80000000000000000000000000000000 0 80000000000000000000000000000000

// bit 0 of every segment
5 0 00010001000100010001000100010001 3 00010001000100010001000000000000

// mixed pattern inside segment 2
6 1 00000000000000000000A5A500000000 5 00000000000000000000A40000000000

// bits at both ends of the word
7 7 F000000000000000000000000000000F 4 F0000000000000000000000000000000

// empty word
8 15 00000000000000000000000000000000 0 00000000000000000000000000000000

// top bit of segments 0 to 4
9 0 00000000000080008000800080008000 2 00000000000080008000800000000000

// top of segment 0 then bottom of segment 7
10 1 0003000000000000000000000000C000 3 00020000000000000000000000000000

// alternating bits, four full segments and one more bit
11 7 55555555555555555555555555555555 33 55555555555555540000000000000000

// one bit in segment 0 and one in segment 7
12 15 01000000000000000000000000000800 1 01000000000000000000000000000000

// top of segment 0 and bottom of segment 1
13 0 00000000000000000000000000018000 1 00000000000000000000000000010000

// full top segment, all but its highest bit cleared
14 1 FFFF0000000000000000000000000000 15 80000000000000000000000000000000

// segment 4 low byte drained completely
15 7 00000000000000FF0000000000000000 8 00000000000000000000000000000000

// two nibbles in segment 0 with the longest delay
16 15 00000000000000000000000000000F0F 6 00000000000000000000000000000C00

//--- files.f
source/truncate_pkg.sv
source/latch_delay.sv
source/cluster_segment.sv
source/segment_keep_chain.sv
source/truncate_clusters.sv
testbench/tb_truncate_clusters.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the cluster truncator testbench with Verilator, run it and check the log
set -e

cd "$(dirname "$0")"

BUILD_DIR=obj_dir
LOG_FILE=sim.log

verilator --binary --timing -Wno-fatal \
  --timescale 1ns/1ns \
  --top-module tb_truncate_clusters \
  --Mdir "$BUILD_DIR" \
  -o tb_truncate_clusters \
  -f files.f

"./$BUILD_DIR/tb_truncate_clusters" | tee "$LOG_FILE"

if grep -q "ALL TESTS PASSED" "$LOG_FILE"; then
  echo "simulation passed"
  exit 0
else
  echo "simulation failed, see $LOG_FILE"
  exit 1
fi
